//--- exe_pkg.sv
// shared types for the execute slice: widths, opcode enums, request and response structs
package exe_pkg;

    localparam int XLEN = 64;  // data path width

    typedef logic [XLEN-1:0] bus64_t;   // operand / result word
    typedef logic [XLEN-1:0] addrPC_t;  // program counter
    typedef logic [4:0]      reg_idx_t; // architectural register index

    // kind of control transfer, CT_NONE for plain alu work
    typedef enum logic [1:0] {
        CT_NONE   = 2'd0,
        CT_JAL    = 2'd1,
        CT_JALR   = 2'd2,
        CT_BRANCH = 2'd3
    } ctrl_xfer_op_t;

    typedef enum logic [2:0] {
        B_EQ  = 3'd0,
        B_NE  = 3'd1,
        B_LT  = 3'd2, // signed
        B_GE  = 3'd3, // signed
        B_LTU = 3'd4,
        B_GEU = 3'd5
    } branch_op_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // decoded instruction from the front end, one cycle strobe
    typedef struct packed {
        logic          valid;
        ctrl_xfer_op_t ctrl_xfer_op;
        branch_op_t    branch_op;
        alu_op_t       alu_op;
        logic          use_imm;  // imm replaces rs2 as alu operand b
        logic          rd_we;
        reg_idx_t      rs1;
        reg_idx_t      rs2;
        reg_idx_t      rd;
        addrPC_t       pc;
        bus64_t        imm;
    } exe_req_t;

    // one per surviving instruction
    typedef struct packed {
        logic     valid;
        logic     taken;
        addrPC_t  target;
        addrPC_t  next_pc;
        reg_idx_t rd;
        logic     wb_en;
        bus64_t   wb_data;
    } exe_resp_t;

endpackage

//--- regfile.sv
// integer register file: two combinational read ports, one write port, x0 hardwired
`timescale 1ns/1ps

module regfile #(
    parameter int NREGS = 32
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  exe_pkg::reg_idx_t rs1_idx_i,
    input  exe_pkg::reg_idx_t rs2_idx_i,
    output exe_pkg::bus64_t   rs1_data_o,
    output exe_pkg::bus64_t   rs2_data_o,
    input  logic             wr_en_i,
    input  exe_pkg::reg_idx_t wr_idx_i,
    input  exe_pkg::bus64_t   wr_data_i
);
    import exe_pkg::*;

    bus64_t regs [NREGS]; // slot 0 kept but never written

    logic rs1_ok;
    logic rs2_ok;
    logic wr_ok;

    // index in range and not x0
    assign rs1_ok = (rs1_idx_i != '0) && (int'(rs1_idx_i) < NREGS);
    assign rs2_ok = (rs2_idx_i != '0) && (int'(rs2_idx_i) < NREGS);
    assign wr_ok  = wr_en_i && (wr_idx_i != '0) && (int'(wr_idx_i) < NREGS);

    // reads see the old value on a same cycle write, bypass lives in control
    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (rs1_ok) begin
            rs1_data_o = regs[rs1_idx_i];
        end
        if (rs2_ok) begin
            rs2_data_o = regs[rs2_idx_i];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

//--- exe_control.sv
// pipeline control: stage 1/2 registers, operand bypass, squash, write back and response
`timescale 1ns/1ps

module exe_control #(
    parameter int NREGS = 32
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  exe_pkg::exe_req_t      issue_i,
    // register file
    output exe_pkg::reg_idx_t      rs1_idx_o,
    output exe_pkg::reg_idx_t      rs2_idx_o,
    input  exe_pkg::bus64_t        rs1_data_i,
    input  exe_pkg::bus64_t        rs2_data_i,
    output logic                   wr_en_o,
    output exe_pkg::reg_idx_t      wr_idx_o,
    output exe_pkg::bus64_t        wr_data_o,
    // alu
    output exe_pkg::alu_op_t       alu_op_o,
    output exe_pkg::bus64_t        op_a_o,
    output exe_pkg::bus64_t        op_b_o,
    input  exe_pkg::bus64_t        alu_result_i,
    // branch unit
    output exe_pkg::ctrl_xfer_op_t ctrl_xfer_op_o,
    output exe_pkg::branch_op_t    branch_op_o,
    output exe_pkg::addrPC_t       pc_o,
    output exe_pkg::bus64_t        imm_o,
    input  logic                   taken_i,
    input  exe_pkg::addrPC_t       target_i,
    input  exe_pkg::addrPC_t       next_pc_i,
    input  exe_pkg::bus64_t        link_data_i,
    output exe_pkg::exe_resp_t     resp_o
);
    import exe_pkg::*;

    // stage 2 keeps the request plus its resolved operands
    typedef struct packed {
        exe_req_t req;
        bus64_t   rs1_val;
        bus64_t   rs2_val;
    } s2_t;

    exe_req_t s1_q;
    s2_t      s2_q;

    logic   s2_is_xfer;   // jump or branch sitting in stage 2
    logic   squash;
    logic   byp_ok;       // stage 2 write target exists in the file
    bus64_t rs1_fwd;
    bus64_t rs2_fwd;

    assign rs1_idx_o = s1_q.rs1;
    assign rs2_idx_o = s1_q.rs2;

    assign s2_is_xfer = s2_q.req.valid && (s2_q.req.ctrl_xfer_op != CT_NONE);
    assign squash     = taken_i; // taken only ever set for a valid s2 transfer

    // write back from stage 2
    assign wr_en_o   = s2_q.req.valid && s2_q.req.rd_we && (s2_q.req.rd != '0);
    assign wr_idx_o  = s2_q.req.rd;
    assign wr_data_o = s2_is_xfer ? link_data_i : alu_result_i; // link is pc+4

    // bypass the stage 2 result into stage 1 reads
    assign byp_ok  = wr_en_o && (int'(s2_q.req.rd) < NREGS);
    assign rs1_fwd = (byp_ok && (wr_idx_o == s1_q.rs1)) ? wr_data_o : rs1_data_i;
    assign rs2_fwd = (byp_ok && (wr_idx_o == s1_q.rs2)) ? wr_data_o : rs2_data_i;

    // pipeline registers
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_q <= '0;
            s2_q <= '0;
        end else begin
            s1_q         <= issue_i;
            s2_q.req     <= s1_q;
            s2_q.rs1_val <= rs1_fwd;
            s2_q.rs2_val <= rs2_fwd;
            s2_q.req.valid <= s1_q.valid && !squash; // drop the younger one on taken
        end
    end

    // operands towards alu and branch unit
    assign alu_op_o = s2_q.req.alu_op;
    assign op_a_o   = s2_q.rs1_val;
    // imm only for plain alu work, a transfer sees rs2 here
    assign op_b_o   = (s2_q.req.use_imm && !s2_is_xfer) ? s2_q.req.imm : s2_q.rs2_val;

    assign ctrl_xfer_op_o = s2_is_xfer ? s2_q.req.ctrl_xfer_op : CT_NONE;
    assign branch_op_o    = s2_q.req.branch_op;
    assign pc_o           = s2_q.req.pc;
    assign imm_o          = s2_q.req.imm;

    // response, one per surviving instruction
    always_comb begin
        resp_o         = '0;
        resp_o.valid   = s2_q.req.valid;
        resp_o.taken   = taken_i;
        resp_o.target  = target_i;
        resp_o.next_pc = next_pc_i;
        resp_o.rd      = s2_q.req.rd;
        resp_o.wb_en   = wr_en_o;
        resp_o.wb_data = wr_data_o;
    end

endmodule

//--- alu.sv
// combinational 64-bit integer arithmetic and logic unit
`timescale 1ns/1ps

module alu (
    input  exe_pkg::alu_op_t alu_op_i,
    input  exe_pkg::bus64_t  op_a_i,
    input  exe_pkg::bus64_t  op_b_i,
    output exe_pkg::bus64_t  result_o
);
    import exe_pkg::*;

    logic [5:0] shamt;   // rv64 shift amount
    logic       lt_s;
    logic       lt_u;

    assign shamt = op_b_i[5:0];
    assign lt_s  = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u  = op_a_i < op_b_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: begin
                result_o = op_a_i + op_b_i;
            end
            ALU_SUB: begin
                result_o = op_a_i - op_b_i;
            end
            ALU_AND: begin
                result_o = op_a_i & op_b_i;
            end
            ALU_OR: begin
                result_o = op_a_i | op_b_i;
            end
            ALU_XOR: begin
                result_o = op_a_i ^ op_b_i;
            end
            ALU_SLL: begin
                result_o = op_a_i << shamt;
            end
            ALU_SRL: begin
                result_o = op_a_i >> shamt; // zero fill
            end
            ALU_SRA: begin
                result_o = bus64_t'($signed(op_a_i) >>> shamt); // sign fill
            end
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_s};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_u};
            end
            default: begin
                result_o = '0; // unused encodings
            end
        endcase
    end

endmodule

//--- branch_unit.sv
// jump and branch resolution: condition, target, next pc and link value
`timescale 1ns/1ps

module branch_unit (
    input  exe_pkg::ctrl_xfer_op_t ctrl_xfer_op_i,
    input  exe_pkg::branch_op_t    branch_op_i,
    input  exe_pkg::addrPC_t       pc_i,
    input  exe_pkg::bus64_t        data_rs1_i,
    input  exe_pkg::bus64_t        data_rs2_i,
    input  exe_pkg::bus64_t        imm_i,
    output logic                   taken_o,
    output exe_pkg::addrPC_t       target_o,
    output exe_pkg::addrPC_t       result_o,
    output exe_pkg::bus64_t        reg_data_o
);
    import exe_pkg::*;

    logic    is_eq;
    logic    is_lt;    // signed compare
    logic    is_ltu;
    logic    cond;     // branch condition holds
    addrPC_t pc_plus4;

    assign is_eq    = (data_rs1_i == data_rs2_i);
    assign is_lt    = $signed(data_rs1_i) < $signed(data_rs2_i);
    assign is_ltu   = data_rs1_i < data_rs2_i;
    assign pc_plus4 = pc_i + 64'd4;

    // condition select for conditional branches
    always_comb begin
        case (branch_op_i)
            B_EQ:    cond = is_eq;
            B_NE:    cond = !is_eq;
            B_LT:    cond = is_lt;
            B_GE:    cond = !is_lt;
            B_LTU:   cond = is_ltu;
            B_GEU:   cond = !is_ltu;
            default: cond = 1'b0;    // reserved encodings never taken
        endcase
    end

    always_comb begin
        case (ctrl_xfer_op_i)
            CT_JAL: begin
                taken_o  = 1'b1;
                target_o = pc_i + imm_i;
            end
            CT_JALR: begin
                taken_o  = 1'b1;
                target_o = pc_i + data_rs1_i + imm_i; // no lsb clear
            end
            CT_BRANCH: begin
                taken_o  = cond;
                target_o = pc_i + imm_i;
            end
            default: begin
                taken_o  = 1'b0;
                target_o = '0;
            end
        endcase
    end

    // fall through when not taken
    assign result_o   = taken_o ? target_o : pc_plus4;
    assign reg_data_o = pc_plus4; // link for jal/jalr

endmodule

//--- exe_top.sv
// execute slice top: control, register file, alu and branch unit
`timescale 1ns/1ps

module exe_top #(
    parameter int NREGS = 32
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  exe_pkg::exe_req_t  issue_i,
    output exe_pkg::exe_resp_t resp_o
);
    import exe_pkg::*;

    // register file ports
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    bus64_t   rs1_data;
    bus64_t   rs2_data;
    logic     wr_en;
    reg_idx_t wr_idx;
    bus64_t   wr_data;

    // stage 2 operands
    alu_op_t       alu_op;
    bus64_t        op_a;
    bus64_t        op_b;
    bus64_t        alu_result;
    ctrl_xfer_op_t ctrl_xfer_op;
    branch_op_t    branch_op;
    addrPC_t       pc;
    bus64_t        imm;

    // branch unit results
    logic    taken;
    addrPC_t target;
    addrPC_t next_pc;
    bus64_t  link_data;

    exe_control #(
        .NREGS(NREGS)
    ) u_control (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .issue_i       (issue_i),
        .rs1_idx_o     (rs1_idx),
        .rs2_idx_o     (rs2_idx),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .wr_en_o       (wr_en),
        .wr_idx_o      (wr_idx),
        .wr_data_o     (wr_data),
        .alu_op_o      (alu_op),
        .op_a_o        (op_a),
        .op_b_o        (op_b),
        .alu_result_i  (alu_result),
        .ctrl_xfer_op_o(ctrl_xfer_op),
        .branch_op_o   (branch_op),
        .pc_o          (pc),
        .imm_o         (imm),
        .taken_i       (taken),
        .target_i      (target),
        .next_pc_i     (next_pc),
        .link_data_i   (link_data),
        .resp_o        (resp_o)
    );

    regfile #(
        .NREGS(NREGS)
    ) u_regfile (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .rs1_idx_i (rs1_idx),
        .rs2_idx_i (rs2_idx),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_data)
    );

    alu u_alu (
        .alu_op_i(alu_op),
        .op_a_i  (op_a),
        .op_b_i  (op_b),
        .result_o(alu_result)
    );

    // op_b carries rs2 whenever a transfer is in stage 2
    branch_unit u_branch (
        .ctrl_xfer_op_i(ctrl_xfer_op),
        .branch_op_i   (branch_op),
        .pc_i          (pc),
        .data_rs1_i    (op_a),
        .data_rs2_i    (op_b),
        .imm_i         (imm),
        .taken_o       (taken),
        .target_o      (target),
        .result_o      (next_pc),
        .reg_data_o    (link_data)
    );

endmodule

//--- tb_clkgen.sv
// testbench clock and reset source
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_PERIOD_NS = 4,  // 8 ns clock
    parameter int RST_CYCLES     = 8
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // release just after an edge, away from the flops
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule

//--- tb_exe_top.sv
// execute slice testbench with directed tests, reference model and response monitor
`timescale 1ns/1ps

module tb_exe_top;
    import exe_pkg::*;

    localparam int NREGS = 32;
    localparam bus64_t MSB  = 64'h8000_0000_0000_0000;
    localparam bus64_t ONES = 64'hFFFF_FFFF_FFFF_FFFF;

    logic      clk;
    logic      arst_n;
    exe_req_t  issue_req;
    exe_resp_t resp;

    bus64_t      shadow [64];     // architectural view of the register file
    exe_resp_t   exp_q [$];       // expected responses, oldest first
    int          due_q [$];       // negedge count at which each one is due
    int          ncyc = 0;        // negedges seen so far
    logic        squash_next;     // last issue was a taken transfer
    logic [31:0] lfsr_state;

    tb_clkgen #(.HALF_PERIOD_NS(4), .RST_CYCLES(8)) u_clkgen (.clk_o(clk), .arst_n_o(arst_n));

    exe_top #(.NREGS(NREGS)) uut (.clk_i(clk), .arst_n_i(arst_n), .issue_i(issue_req),
        .resp_o(resp));

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_reg(input bus64_t got, input bus64_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH @ %0t: %s got %h exp %h", $time, what, got, exp));
        end
    endtask

    // control fields compared before the data word
    task automatic check_resp(input exe_resp_t got, input exe_resp_t exp);
        exe_resp_t g;
        exe_resp_t e;
        string     got_s;
        string     exp_s;
        g = got;
        e = exp;
        g.wb_data = '0;
        e.wb_data = '0;
        if (g !== e) begin
            got_s = $sformatf("t=%b tgt=%h npc=%h wb_en=%b",
                got.taken, got.target, got.next_pc, got.wb_en);
            exp_s = $sformatf("t=%b tgt=%h npc=%h wb_en=%b",
                exp.taken, exp.target, exp.next_pc, exp.wb_en);
            stop_on_error($sformatf("MISMATCH @ %0t: rd x%0d got %s exp %s",
                $time, exp.rd, got_s, exp_s));
        end
        check_reg(got.wb_data, exp.wb_data, $sformatf("wb_data of x%0d", exp.rd));
    endtask

    // one step of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function bus64_t rand64();
        bus64_t r;
        r = '0;
        for (int i = 0; i < 64; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic bus64_t reg_val(input reg_idx_t r);
        if (r == '0 || int'(r) >= NREGS) begin
            return '0;  // x0 and missing registers
        end
        return shadow[{1'b0, r}];
    endfunction

    function automatic bus64_t model_alu(input alu_op_t op, input bus64_t a, input bus64_t b);
        logic [5:0] sh;
        sh = b[5:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (a[63] ? ~(ONES >> sh) : 64'd0); // refill sign bits
            ALU_SLT:  return 64'((a ^ MSB) < (b ^ MSB));  // flipped sign gives signed order
            ALU_SLTU: return 64'(a < b);
            default:  return '0;
        endcase
    endfunction

    function automatic logic model_cond(input branch_op_t op, input bus64_t a, input bus64_t b);
        case (op)
            B_EQ:    return a == b;
            B_NE:    return a != b;
            B_LT:    return (a ^ MSB) < (b ^ MSB);
            B_GE:    return (a ^ MSB) >= (b ^ MSB);
            B_LTU:   return a < b;
            B_GEU:   return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // expected response under sequential semantics
    function automatic exe_resp_t expect_resp(input exe_req_t r);
        exe_resp_t e;
        bus64_t    a;
        bus64_t    b;
        a = reg_val(r.rs1);
        b = reg_val(r.rs2);
        e = '0;
        e.valid   = 1'b1;
        e.rd      = r.rd;
        e.wb_en   = r.rd_we && (r.rd != '0);
        e.next_pc = r.pc + 64'd4;
        e.wb_data = r.pc + 64'd4;  // link for any transfer
        case (r.ctrl_xfer_op)
            CT_JAL: begin
                e.taken  = 1'b1;
                e.target = r.pc + r.imm;
            end
            CT_JALR: begin
                e.taken  = 1'b1;
                e.target = r.pc + a + r.imm;
            end
            CT_BRANCH: begin
                e.taken  = model_cond(r.branch_op, a, b);
                e.target = r.pc + r.imm;
            end
            default: begin
                e.wb_data = model_alu(r.alu_op, a, r.use_imm ? r.imm : b);
            end
        endcase
        if (e.taken) begin
            e.next_pc = e.target;
        end
        return e;
    endfunction

    function automatic exe_req_t mk_alu(input alu_op_t op, input reg_idx_t rd,
                                        input reg_idx_t rs1, input reg_idx_t rs2,
                                        input logic use_imm, input bus64_t imm);
        exe_req_t r;
        r = '0;
        r.valid   = 1'b1;
        r.alu_op  = op;
        r.use_imm = use_imm;
        r.rd_we   = 1'b1;
        r.rs1     = rs1;
        r.rs2     = rs2;
        r.rd      = rd;
        r.pc      = 64'h0000_0000_8000_0000;
        r.imm     = imm;
        return r;
    endfunction

    function automatic exe_req_t mk_xfer(input ctrl_xfer_op_t ct, input branch_op_t bop,
                                         input reg_idx_t rd, input reg_idx_t rs1,
                                         input reg_idx_t rs2, input addrPC_t pc,
                                         input bus64_t imm);
        exe_req_t r;
        r = '0;
        r.valid        = 1'b1;
        r.ctrl_xfer_op = ct;
        r.branch_op    = bop;
        r.rd_we        = (ct != CT_BRANCH); // branches link nothing
        r.rs1          = rs1;
        r.rs2          = rs2;
        r.rd           = rd;
        r.pc           = pc;
        r.imm          = imm;
        return r;
    endfunction

    // drives one request 1 ns after the edge
    task automatic issue(input exe_req_t req);
        exe_resp_t e;
        @(posedge clk);
        #1;
        issue_req = req;
        if (squash_next) begin
            squash_next = 1'b0;  // younger one dropped with no response and no write
        end else begin
            e = expect_resp(req);
            if (e.wb_en && int'(req.rd) < NREGS) begin
                shadow[{1'b0, req.rd}] = e.wb_data;
            end
            exp_q.push_back(e);
            due_q.push_back(ncyc + 3);  // sampled two edges after capture
            squash_next = e.taken;
        end
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        issue_req   = '0;
        squash_next = 1'b0;
    endtask

    // add rs1 + x0 without a write shows the register in wb_data
    task automatic read_reg(input reg_idx_t r);
        exe_req_t req;
        req = mk_alu(ALU_ADD, 5'd31, r, 5'd0, 1'b0, '0);
        req.rd_we = 1'b0;
        issue(req);
    endtask

    task automatic drain();
        int n;
        n = 0;
        idle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                stop_on_error("timeout: responses still missing after 20 cycles");
            end
        end
    endtask

    // checks every response at its fixed due cycle
    always @(negedge clk) begin : resp_monitor
        exe_resp_t e;
        int        d;
        ncyc++;
        if (resp.valid) begin
            if (exp_q.size() == 0) begin
                stop_on_error("a response appeared with no instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                d = due_q.pop_front();
                if (d != ncyc) begin
                    stop_on_error($sformatf(
                        "MISMATCH @ %0t: response for x%0d at cycle %0d, exp %0d",
                        $time, e.rd, ncyc, d));
                end
                check_resp(resp, e);
            end
        end else if (due_q.size() != 0 && due_q[0] <= ncyc) begin
            stop_on_error("an expected response did not arrive on its cycle");
        end
    end

    task automatic test_reset_and_load();
        repeat (4) begin
            @(negedge clk);
            if (resp.valid !== 1'b0) begin
                stop_on_error($sformatf("MISMATCH @ %0t: resp valid high after reset", $time));
            end
        end
        for (int k = 1; k < 8; k++) begin
            issue(mk_alu(ALU_ADD, reg_idx_t'(k[4:0]), 5'd0, 5'd0, 1'b1, rand64()));
        end
        issue(mk_alu(ALU_ADD, 5'd0, 5'd0, 5'd0, 1'b1, 64'h55)); // x0 must ignore this
        idle();
        for (int k = 0; k < 8; k++) begin
            read_reg(reg_idx_t'(k[4:0]));
        end
        drain();
    endtask

    task automatic test_alu_ops();
        alu_op_t op;
        for (int k = 0; k < 10; k++) begin
            op = alu_op_t'(k[3:0]);
            issue(mk_alu(ALU_ADD, 5'd8, 5'd0, 5'd0, 1'b1, rand64()));
            issue(mk_alu(ALU_ADD, 5'd9, 5'd0, 5'd0, 1'b1, rand64()));
            issue(mk_alu(op, 5'd10, 5'd8, 5'd9, 1'b0, '0));       // register form
            issue(mk_alu(op, 5'd11, 5'd8, 5'd0, 1'b1, rand64())); // immediate form
        end
        drain();
    endtask

    task automatic test_branches();
        bus64_t a;
        bus64_t b;
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 5; p++) begin
                // pairs 3 and 4 order differently as signed and unsigned
                case (p)
                    0:       {a, b} = {64'h1234, 64'h1234};
                    1:       {a, b} = {64'd1, 64'd7};
                    2:       {a, b} = {64'd7, 64'd1};
                    3:       {a, b} = {64'hFFFF_FFFF_FFFF_FFF0, 64'd5};
                    default: {a, b} = {64'd5, 64'hFFFF_FFFF_FFFF_FFF0};
                endcase
                issue(mk_alu(ALU_ADD, 5'd12, 5'd0, 5'd0, 1'b1, a));
                issue(mk_alu(ALU_ADD, 5'd13, 5'd0, 5'd0, 1'b1, b));
                issue(mk_xfer(CT_BRANCH, branch_op_t'(k[2:0]), 5'd0, 5'd12, 5'd13,
                    rand64(), rand64()));
                idle();  // keep the next load out of the squash slot
            end
        end
        drain();
    endtask

    task automatic test_jumps();
        issue(mk_xfer(CT_JAL, B_EQ, 5'd14, 5'd0, 5'd0, rand64(), rand64()));
        idle();
        read_reg(5'd14);  // link value landed
        issue(mk_alu(ALU_ADD, 5'd15, 5'd0, 5'd0, 1'b1, rand64()));
        issue(mk_xfer(CT_JALR, B_EQ, 5'd16, 5'd15, 5'd0, rand64(), rand64())); // rs1 bypassed
        idle();
        read_reg(5'd16);
        drain();
    endtask

    task automatic test_back_to_back();
        issue(mk_alu(ALU_ADD, 5'd17, 5'd0, 5'd0, 1'b1, rand64()));
        issue(mk_alu(ALU_ADD, 5'd18, 5'd17, 5'd17, 1'b0, '0));   // both operands bypassed
        issue(mk_alu(ALU_SUB, 5'd19, 5'd18, 5'd17, 1'b0, '0));   // bypass plus file read
        issue(mk_alu(ALU_XOR, 5'd17, 5'd19, 5'd0, 1'b1, rand64()));
        issue(mk_alu(ALU_SLTU, 5'd18, 5'd19, 5'd17, 1'b0, '0));
        issue(mk_alu(ALU_SRA, 5'd19, 5'd17, 5'd18, 1'b0, '0));
        issue(mk_alu(ALU_OR, 5'd20, 5'd19, 5'd17, 1'b0, '0));
        drain();
    endtask

    task automatic test_squash();
        issue(mk_alu(ALU_ADD, 5'd20, 5'd0, 5'd0, 1'b1, 64'h1111));
        idle();
        issue(mk_xfer(CT_BRANCH, B_EQ, 5'd0, 5'd0, 5'd0, rand64(), rand64())); // always taken
        issue(mk_alu(ALU_ADD, 5'd20, 5'd0, 5'd0, 1'b1, 64'h2222));            // squashed
        read_reg(5'd20);  // still the old value
        issue(mk_xfer(CT_JAL, B_EQ, 5'd22, 5'd0, 5'd0, rand64(), rand64()));
        issue(mk_alu(ALU_ADD, 5'd21, 5'd0, 5'd0, 1'b1, 64'h3333));            // squashed
        read_reg(5'd21);
        issue(mk_xfer(CT_BRANCH, B_NE, 5'd0, 5'd0, 5'd0, rand64(), rand64())); // not taken
        issue(mk_alu(ALU_ADD, 5'd21, 5'd0, 5'd0, 1'b1, 64'h4444));            // survives
        read_reg(5'd21);
        drain();
    endtask

    initial begin
        int n;
        issue_req   = '0;
        squash_next = 1'b0;
        lfsr_state  = 32'h7557_fc9e;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        n = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                stop_on_error("reset was never released");
            end
        end
        test_reset_and_load();
        test_alu_ops();
        test_branches();
        test_jumps();
        test_back_to_back();
        test_squash();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- sim.f
exe_pkg.sv
regfile.sv
exe_control.sv
alu.sv
branch_unit.sv
exe_top.sv
tb_clkgen.sv
tb_exe_top.sv

//--- run.sh
#!/bin/sh
# build the execute slice testbench with Verilator, run it, look for the pass line
verilator --binary --timing -j 0 --top-module tb_exe_top -f sim.f -o sim_exe \
    && ./obj_dir/sim_exe | tee /dev/stderr | grep -q "^=== PASS ===$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
